//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_fm_core
FILELIST = build.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- build.f
+incdir+rtl
rtl/fm_pkg.sv
rtl/fm_reg_file.sv
rtl/fm_phase_gen.sv
rtl/fm_tables.sv
rtl/fm_operator.sv
rtl/fm_mixer.sv
rtl/fm_core.sv
testbench/fm_checker.sv
testbench/tb_fm_core.sv

//--- rtl/fm_core.sv
// No clock enable and no read-back; samples not taken on sample_stb are lost
`include "fm_params.svh"

module fm_core import fm_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        wr_stb,
    input  logic [2:0]                  wr_addr,
    input  fm_reg_word_u                wr_data,
    input  logic                        sync,
    output logic signed [`FM_MIX_W-1:0] sample_ch0,
    output logic signed [`FM_MIX_W-1:0] sample_ch1,
    output logic                        sample_stb
);

    // Slot sequence
    fm_slot_t                    slot;
    logic [9:0]                  phase;

    // Current slot settings
    logic [`FM_PHASE_W-1:0]      phase_inc;
    logic [9:0]                  atten;
    logic [2:0]                  fb;
    logic                        algo;

    // Operator results
    logic signed [`FM_OUT_W-1:0] op_out;
    fm_slot_t                    op_slot;
    logic                        op_valid;

    fm_reg_file reg_file_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_stb    (wr_stb),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .slot      (slot),
        .phase_inc (phase_inc),
        .atten     (atten),
        .fb        (fb),
        .algo      (algo)
    );

    // Frame marker left open, the slot index already carries it
    fm_phase_gen phase_gen_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .sync        (sync),
        .phase_inc   (phase_inc),
        .slot        (slot),
        .phase       (phase),
        .frame_start ()
    );

    fm_operator operator_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .sync     (sync),
        .slot     (slot),
        .phase    (phase),
        .atten    (atten),
        .fb       (fb),
        .algo     (algo),
        .op_out   (op_out),
        .op_slot  (op_slot),
        .op_valid (op_valid)
    );

    fm_mixer mixer_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .sync       (sync),
        .op_out     (op_out),
        .op_slot    (op_slot),
        .op_valid   (op_valid),
        .algo       (algo),
        .sample_ch0 (sample_ch0),
        .sample_ch1 (sample_ch1),
        .sample_stb (sample_stb)
    );

endmodule

//--- rtl/fm_mixer.sv
// sample_ch1 and sample_stb are combinational from the operator output; ch0 is held from slot 2
`include "fm_params.svh"

module fm_mixer import fm_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        sync,
    input  logic signed [`FM_OUT_W-1:0] op_out,
    input  fm_slot_t                    op_slot,
    input  logic                        op_valid,
    input  logic                        algo,
    output logic signed [`FM_MIX_W-1:0] sample_ch0,
    output logic signed [`FM_MIX_W-1:0] sample_ch1,
    output logic                        sample_stb
);

    // Algorithm lined up with the operator output
    logic [`FM_OP_LAT-1:0]       algo_d;
    logic signed [`FM_OUT_W-1:0] mod_q [2];
    logic signed [`FM_MIX_W-1:0] ch0_q;
    logic signed [`FM_MIX_W-1:0] car_ext;
    logic signed [`FM_MIX_W-1:0] mod_ext;
    logic signed [`FM_MIX_W-1:0] mix;

    assign car_ext = {{(`FM_MIX_W-`FM_OUT_W){op_out[`FM_OUT_W-1]}}, op_out};
    assign mod_ext = {{(`FM_MIX_W-`FM_OUT_W){mod_q[op_slot[0]][`FM_OUT_W-1]}}, mod_q[op_slot[0]]};

    // Additive mode adds this frame's modulator
    assign mix = algo_d[`FM_OP_LAT-1] ? car_ext + mod_ext : car_ext;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            algo_d   <= '0;
            mod_q[0] <= '0;
            mod_q[1] <= '0;
            ch0_q    <= '0;
        end else begin
            algo_d <= {algo_d[`FM_OP_LAT-2:0], algo};
            if (op_valid && !op_slot[1])
                mod_q[op_slot[0]] <= op_out;
            if (op_valid && op_slot == 2'd2)
                ch0_q <= mix;
        end
    end

    assign sample_ch0 = ch0_q;
    assign sample_ch1 = mix;

    // Carrier of channel 1 closes the frame
    assign sample_stb = op_valid && op_slot == 2'd3 && !sync;

    // Steady frame rate between syncs
    assert property (@(posedge clk) disable iff (!rst_n || sync)
        sample_stb |=> (!sample_stb) [*3] ##1 sample_stb);

endmodule

//--- rtl/fm_operator.sv
// Items issued before a sync never become valid; history reads assume the fixed slot order
`include "fm_params.svh"

module fm_operator import fm_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        sync,
    input  fm_slot_t                    slot,
    input  logic [9:0]                  phase,
    input  logic [9:0]                  atten,
    input  logic [2:0]                  fb,
    input  logic                        algo,
    output logic signed [`FM_OUT_W-1:0] op_out,
    output fm_slot_t                    op_slot,
    output logic                        op_valid
);

    localparam int CHANNELS = `FM_SLOTS / 2;

    // Modulator outputs, prev1 one frame older than the one now leaving
    logic signed [`FM_OUT_W-1:0] prev1 [CHANNELS];
    logic signed [`FM_OUT_W-1:0] prev2 [CHANNELS];

    logic        ch;
    logic        is_mod;
    logic [14:0] pm_sum;
    logic [9:0]  phase_mod;
    logic [9:0]  op_phase;
    logic [7:0]  sin_addr;
    logic [7:0]  exp_addr;
    logic [11:0] logsin;
    logic [9:0]  expo;
    logic [12:0] total_raw;
    logic [11:0] total;
    logic [11:0] mant;
    logic signed [`FM_OUT_W-1:0] mag_ext;

    // Stage registers
    logic        s1_sign, s2_sign, s3_sign;
    logic [9:0]  s1_atten;
    logic [3:0]  s2_shift;
    logic [11:0] s3_mag;
    fm_slot_t    s1_slot, s2_slot, s3_slot;
    logic        s1_valid, s2_valid, s3_valid;

    // Stage 1, modulation and phase fold
    assign ch     = slot[0];
    assign is_mod = !slot[1];
    assign pm_sum = {prev1[ch][`FM_OUT_W-1], prev1[ch]} + {prev2[ch][`FM_OUT_W-1], prev2[ch]};

    always_comb begin
        if (is_mod) begin
            // Self feedback windows of the two-frame sum
            case (fb)
                3'd1:    phase_mod = {{4{pm_sum[14]}}, pm_sum[14:9]};
                3'd2:    phase_mod = {{3{pm_sum[14]}}, pm_sum[14:8]};
                3'd3:    phase_mod = {{2{pm_sum[14]}}, pm_sum[14:7]};
                3'd4:    phase_mod = {pm_sum[14], pm_sum[14:6]};
                3'd5:    phase_mod = pm_sum[14:5];
                3'd6:    phase_mod = pm_sum[13:4];
                3'd7:    phase_mod = pm_sum[12:3];
                default: phase_mod = '0;
            endcase
        end else begin
            // Carrier takes last frame's modulator, or nothing when additive
            phase_mod = algo ? '0 : prev1[ch][10:1];
        end
    end

    assign op_phase = phase + phase_mod;

    // Second quarter mirrors the first
    assign sin_addr = op_phase[8] ? ~op_phase[7:0] : op_phase[7:0];

    // Stage 2, attenuation add with saturation
    assign total_raw = {1'b0, logsin} + {1'b0, s1_atten, 2'b00};
    assign total     = total_raw[12] ? 12'hfff : total_raw[11:0];
    assign exp_addr  = ~total[7:0];

    // Stage 3, hidden leading one then octave shift
    assign mant = {1'b1, expo, 1'b0};

    // Stage 4, sign applied
    assign mag_ext = {2'b00, s3_mag};

    fm_tables tables_i (
        .clk      (clk),
        .sin_addr (sin_addr),
        .exp_addr (exp_addr),
        .logsin   (logsin),
        .expo     (expo)
    );

    always_ff @(posedge clk) begin
        s1_sign  <= op_phase[9];
        s1_atten <= atten;
        s1_slot  <= slot;
        s2_shift <= total[11:8];
        s2_sign  <= s1_sign;
        s2_slot  <= s1_slot;
        s3_mag   <= mant >> s2_shift;
        s3_sign  <= s2_sign;
        s3_slot  <= s2_slot;
        op_out   <= s3_sign ? -mag_ext : mag_ext;
        op_slot  <= s3_slot;
    end

    // Sync flushes everything in flight
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
            op_valid <= 1'b0;
        end else begin
            s1_valid <= !sync;
            s2_valid <= s1_valid && !sync;
            s3_valid <= s2_valid && !sync;
            op_valid <= s3_valid && !sync;
        end
    end

    // History shifts as each modulator result leaves
    always_ff @(posedge clk) begin
        if (!rst_n || sync) begin
            for (int c = 0; c < CHANNELS; c++) begin
                prev1[c] <= '0;
                prev2[c] <= '0;
            end
        end else if (op_valid && !op_slot[1]) begin
            prev2[op_slot[0]] <= prev1[op_slot[0]];
            prev1[op_slot[0]] <= op_out;
        end
    end

    // Output tag matches the slot that entered four cycles earlier
    assert property (@(posedge clk) disable iff (!rst_n)
        op_valid |-> op_slot == $past(slot, `FM_OP_LAT));

endmodule

//--- rtl/fm_params.svh
// Sizes are fixed for a four-slot, two-channel core; the widths are not meant to be changed alone
`ifndef FM_PARAMS_SVH
`define FM_PARAMS_SVH

// Operator slots per frame, two modulators then two carriers
`define FM_SLOTS 4

// Phase accumulator width, top 10 bits feed the operator
`define FM_PHASE_W 20

// Signed operator sample width
`define FM_OUT_W 14

// Signed channel sample width after mixing
`define FM_MIX_W 16

// Cycles from slot phase to operator output
`define FM_OP_LAT 4

`endif

//--- rtl/fm_phase_gen.sv
// Runs on every clock with no enable; sync or reset restarts at slot 0 with all phases zero
`include "fm_params.svh"

module fm_phase_gen import fm_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    sync,
    input  logic [`FM_PHASE_W-1:0]  phase_inc,
    output fm_slot_t                slot,
    output logic [9:0]              phase,
    output logic                    frame_start
);

    // Slot counter wraps every frame
    fm_slot_t slot_q;

    // One accumulator per slot
    logic [`FM_PHASE_W-1:0] acc [`FM_SLOTS];

    always_ff @(posedge clk) begin
        if (!rst_n || sync) begin
            slot_q <= '0;
            for (int s = 0; s < `FM_SLOTS; s++) begin
                acc[s] <= '0;
            end
        end else begin
            slot_q <= slot_q + 1'b1;
            // Only the current slot advances
            acc[slot_q] <= acc[slot_q] + phase_inc;
        end
    end

    assign slot = slot_q;

    // Phase shown before this cycle's add
    assign phase = acc[slot_q][`FM_PHASE_W-1 -: 10];

    // Marks the first modulator of a frame
    assign frame_start = (slot_q == '0);

endmodule

//--- rtl/fm_pkg.sv
// Host words are 16 bits; the two top bits of either view are spare and ignored
`include "fm_params.svh"

package fm_pkg;

    // Slot index, advances once per clock
    typedef logic [$clog2(`FM_SLOTS)-1:0] fm_slot_t;

    // One host data word, read as frequency or as level settings
    typedef union packed {
        // Address bit 0 low
        struct packed {
            logic [1:0]  spare;
            logic [2:0]  block;
            logic [10:0] fnum;
        } freq;
        // Address bit 0 high
        struct packed {
            logic [1:0]  spare;
            logic        algo;
            logic [2:0]  fb;
            logic [9:0]  atten;
        } level;
    } fm_reg_word_u;

endpackage

//--- rtl/fm_reg_file.sv
// Settings are write-only and take effect on the next slot cycle; algo is read from the modulator slot
`include "fm_params.svh"

module fm_reg_file import fm_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    wr_stb,
    input  logic [2:0]              wr_addr,
    input  fm_reg_word_u            wr_data,
    input  fm_slot_t                slot,
    output logic [`FM_PHASE_W-1:0]  phase_inc,
    output logic [9:0]              atten,
    output logic [2:0]              fb,
    output logic                    algo
);

    // Per-slot frequency and level words
    fm_reg_word_u freq_q  [`FM_SLOTS];
    fm_reg_word_u level_q [`FM_SLOTS];
    fm_slot_t     wr_slot;
    fm_reg_word_u cur_freq;
    fm_reg_word_u cur_level;
    fm_slot_t     mod_slot;

    // Address bits 2:1 pick the slot
    assign wr_slot = wr_addr[2:1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < `FM_SLOTS; s++) begin
                freq_q[s]  <= '0;
                level_q[s] <= '0;
            end
        end else if (wr_stb) begin
            // Bit 0 picks the view
            if (wr_addr[0])
                level_q[wr_slot] <= wr_data;
            else
                freq_q[wr_slot] <= wr_data;
        end
    end

    assign cur_freq  = freq_q[slot];
    assign cur_level = level_q[slot];

    // Increment is fnum scaled up by the octave block
    assign phase_inc = {{(`FM_PHASE_W-11){1'b0}}, cur_freq.freq.fnum} << cur_freq.freq.block;
    assign atten     = cur_level.level.atten;
    assign fb        = cur_level.level.fb;

    // Channel algorithm lives in its modulator slot
    assign mod_slot = {1'b0, slot[0]};
    assign algo     = level_q[mod_slot].level.algo;

    // Host data must be clean whenever it is captured
    assert property (@(posedge clk) disable iff (!rst_n) wr_stb |-> !$isunknown(wr_data));

endmodule

//--- rtl/fm_tables.sv
// ROM contents come from real math at elaboration, so the tool must evaluate $sin, $ln and $pow
module fm_tables (
    input  logic        clk,
    input  logic [7:0]  sin_addr,
    input  logic [7:0]  exp_addr,
    output logic [11:0] logsin,
    output logic [9:0]  expo
);

    localparam real PI = 3.14159265358979;

    // Quarter-wave log-sine, 1/256 octave steps
    logic [11:0] sin_rom [256];

    // Fractional part of 2^x scaled to 10 bits
    logic [9:0]  exp_rom [256];

    real ang;
    real val;

    initial begin
        for (int i = 0; i < 256; i++) begin
            // Sample the middle of each step
            ang = (i + 0.5) * PI / 512.0;
            val = -($ln($sin(ang)) / $ln(2.0)) * 256.0;
            sin_rom[i] = 12'($rtoi(val + 0.5));
        end
        for (int j = 0; j < 256; j++) begin
            val = ($pow(2.0, j / 256.0) - 1.0) * 1024.0;
            exp_rom[j] = 10'($rtoi(val + 0.5));
        end
    end

    // One cycle per lookup
    always_ff @(posedge clk) begin
        logsin <= sin_rom[sin_addr];
        expo   <= exp_rom[exp_addr];
    end

endmodule

//--- testbench/fm_checker.sv
// Follows the DUT slot by slot from its ports; a write counts from the slot cycle after its strobe
`include "fm_params.svh"

module fm_checker import fm_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        wr_stb,
    input  logic [2:0]                  wr_addr,
    input  fm_reg_word_u                wr_data,
    input  logic                        sync,
    input  logic signed [`FM_MIX_W-1:0] sample_ch0,
    input  logic signed [`FM_MIX_W-1:0] sample_ch1,
    input  logic                        sample_stb,
    output int                          mismatch_count,
    output int                          other_count,
    output int                          checked_count
);

    localparam real PI = 3.14159265358979;

    // Table contents straight from the formulas
    int logsin_tab [256];
    int exp_tab    [256];

    // Register model
    logic [10:0] m_fnum  [`FM_SLOTS];
    logic [2:0]  m_block [`FM_SLOTS];
    logic [9:0]  m_atten [`FM_SLOTS];
    logic [2:0]  m_fb    [`FM_SLOTS];
    logic        m_algo  [`FM_SLOTS];

    // Phase model and modulator outputs, index 0 is this frame, 3 is three frames back
    logic [`FM_PHASE_W-1:0] m_acc [`FM_SLOTS];
    int m_slot;
    int mod_out [2][4];
    int car0;
    int frame_no;
    int cmp_no;

    // Expected samples in frame order since the last sync
    int exp_ch0 [$];
    int exp_ch1 [$];

    initial begin
        real v;
        for (int i = 0; i < 256; i++) begin
            v = -($ln($sin((i + 0.5) * PI / 512.0)) / $ln(2.0)) * 256.0;
            logsin_tab[i] = $rtoi(v + 0.5);
        end
        for (int j = 0; j < 256; j++) begin
            v = ($pow(2.0, j / 256.0) - 1.0) * 1024.0;
            exp_tab[j] = $rtoi(v + 0.5);
        end
    end

    // One operator pass, phase plus modulation to signed sample
    function automatic int op_result(input int ph, input int modv, input int att);
        int p;
        int idx;
        int total;
        int mag;
        p = (ph + modv) & 1023;
        // Second quarter mirrors the first
        idx = (p & 256) ? 255 - (p & 255) : p & 255;
        total = logsin_tab[idx] + att * 4;
        if (total > 4095)
            total = 4095;
        mag = ((exp_tab[255 - (total & 255)] + 1024) * 2) >> (total >> 8);
        return (p & 512) ? -mag : mag;
    endfunction

    task automatic restart_model();
        m_slot   = 0;
        frame_no = 0;
        cmp_no   = 0;
        for (int s = 0; s < `FM_SLOTS; s++)
            m_acc[s] = '0;
        for (int k = 0; k < 4; k++) begin
            mod_out[0][k] = 0;
            mod_out[1][k] = 0;
        end
        exp_ch0.delete();
        exp_ch1.delete();
    endtask

    task automatic issue_slot();
        int ch;
        int ph;
        int modv;
        int res;
        ch = m_slot % 2;
        ph = m_acc[m_slot][`FM_PHASE_W-1 -: 10];
        if (m_slot < 2) begin
            for (int k = 3; k > 0; k--)
                mod_out[ch][k] = mod_out[ch][k-1];
            // Feedback window of the sum from frames k-2 and k-3
            modv = (m_fb[m_slot] == 0) ? 0 :
                   ((mod_out[ch][2] + mod_out[ch][3]) >>> (10 - m_fb[m_slot])) & 1023;
            mod_out[ch][0] = op_result(ph, modv, m_atten[m_slot]);
        end else begin
            // Carrier follows last frame's modulator unless additive
            modv = m_algo[ch] ? 0 : (mod_out[ch][1] >>> 1) & 1023;
            res  = op_result(ph, modv, m_atten[m_slot]);
            if (m_algo[ch])
                res = res + mod_out[ch][0];
            if (ch == 0) begin
                car0 = res;
            end else begin
                exp_ch0.push_back(car0);
                exp_ch1.push_back(res);
                if (exp_ch0.size() > 1) begin
                    other_count++;
                    $display("No sample strobe came for frame %0d", frame_no - 1);
                    void'(exp_ch0.pop_front());
                    void'(exp_ch1.pop_front());
                end
            end
        end
        m_acc[m_slot] = m_acc[m_slot] + (int'(m_fnum[m_slot]) << m_block[m_slot]);
        m_slot = (m_slot + 1) % `FM_SLOTS;
        if (m_slot == 0)
            frame_no++;
    endtask

    task automatic check_sample(input string name, input logic [15:0] got, input int exp_val);
        if (got !== 16'(exp_val)) begin
            mismatch_count++;
            $display("mismatch %s frame %0d: got %h expected %h", name, cmp_no, got, 16'(exp_val));
        end
    endtask

    always @(posedge clk) begin
        // Compare first, the strobe belongs to the cycle that just ended
        if (rst_n && sample_stb) begin
            if (exp_ch0.size() == 0) begin
                other_count++;
                $display("Sample strobe at time %0t with no frame pending", $time);
            end else begin
                check_sample("sample_ch0", sample_ch0, exp_ch0.pop_front());
                check_sample("sample_ch1", sample_ch1, exp_ch1.pop_front());
                checked_count++;
                cmp_no++;
            end
        end
        if (!rst_n) begin
            for (int s = 0; s < `FM_SLOTS; s++) begin
                m_fnum[s]  = '0;
                m_block[s] = '0;
                m_atten[s] = '0;
                m_fb[s]    = '0;
                m_algo[s]  = 1'b0;
            end
            restart_model();
        end else begin
            if (sync)
                restart_model();
            else
                issue_slot();
            // Write lands after this cycle's slot used the old value
            if (wr_stb && wr_addr[0]) begin
                m_atten[wr_addr[2:1]] = wr_data.level.atten;
                m_fb[wr_addr[2:1]]    = wr_data.level.fb;
                m_algo[wr_addr[2:1]]  = wr_data.level.algo;
            end else if (wr_stb) begin
                m_fnum[wr_addr[2:1]]  = wr_data.freq.fnum;
                m_block[wr_addr[2:1]] = wr_data.freq.block;
            end
        end
    end

endmodule

//--- testbench/tb_fm_core.sv
// Inputs change 2 time units after each rising edge; random stimulus comes from seed 40655
`include "fm_params.svh"

module tb_fm_core;

    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DLY   = 2;
    // Frames per test
    localparam int ATTEN_FRAMES = 16;
    localparam int TONE_FRAMES  = 64;
    localparam int FM_FRAMES    = 64;
    localparam int FB_FRAMES    = 16;
    localparam int MID_FRAMES   = 32;
    localparam int RAND_ROUNDS  = 12;
    localparam int RAND_FRAMES  = 4;
    // Writes, sync and pipeline fill for each setup
    localparam int SETUP_FRAMES = 4;
    localparam int SETUPS       = 3 + 7 + 2 + RAND_ROUNDS;
    localparam int TOTAL_FRAMES = ATTEN_FRAMES + TONE_FRAMES + FM_FRAMES + 7 * FB_FRAMES
                                + 2 * MID_FRAMES + RAND_ROUNDS * RAND_FRAMES
                                + SETUPS * SETUP_FRAMES + 4;
    localparam int WATCHDOG_TIME = TOTAL_FRAMES * `FM_SLOTS * CLK_PERIOD * 3 / 2;

    logic                        clk;
    logic                        rst_n;
    logic                        wr_stb;
    logic [2:0]                  wr_addr;
    logic [15:0]                 wr_data;
    logic                        sync;
    logic signed [`FM_MIX_W-1:0] sample_ch0;
    logic signed [`FM_MIX_W-1:0] sample_ch1;
    logic                        sample_stb;
    int                          mismatch_count;
    int                          other_count;
    int                          checked_count;
    integer                      seed = 40655;

    fm_core dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_stb     (wr_stb),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .sync       (sync),
        .sample_ch0 (sample_ch0),
        .sample_ch1 (sample_ch1),
        .sample_stb (sample_stb)
    );

    fm_checker chk_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .wr_stb         (wr_stb),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .sync           (sync),
        .sample_ch0     (sample_ch0),
        .sample_ch1     (sample_ch1),
        .sample_stb     (sample_stb),
        .mismatch_count (mismatch_count),
        .other_count    (other_count),
        .checked_count  (checked_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic run_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
    endtask

    task automatic write_reg(input logic [2:0] addr, input logic [15:0] data);
        wr_stb  = 1'b1;
        wr_addr = addr;
        wr_data = data;
        run_cycles(1);
        wr_stb  = 1'b0;
    endtask

    task automatic pulse_sync();
        sync = 1'b1;
        run_cycles(1);
        sync = 1'b0;
    endtask

    // Random pitch and spare bits on every slot; fb goes to modulators only
    task automatic load_all(input logic [9:0] atten_mask, input logic [9:0] atten_set,
                            input logic [2:0] mod_fb, input logic algo);
        logic [15:0] r;
        for (int s = 0; s < `FM_SLOTS; s++) begin
            r = 16'($random(seed));
            write_reg({2'(s), 1'b0}, r);
            r = 16'($random(seed));
            write_reg({2'(s), 1'b1}, {r[15:14], algo, (s < 2) ? mod_fb : 3'd0,
                                      (r[9:0] & atten_mask) | atten_set});
        end
    endtask

    // About one write in eight cycles to any slot and view
    task automatic random_activity(input int frames);
        repeat (frames * `FM_SLOTS) begin
            wr_stb  = (($random(seed) & 7) == 0);
            wr_addr = 3'($random(seed));
            wr_data = 16'($random(seed));
            run_cycles(1);
        end
        wr_stb = 1'b0;
    endtask

    initial begin
        wr_stb  = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        sync    = 1'b0;
        rst_n   = 1'b0;
        repeat (2) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        // Full attenuation everywhere
        load_all(10'h3ff, 10'h3ff, 3'd0, 1'b1);
        pulse_sync();
        run_cycles(ATTEN_FRAMES * `FM_SLOTS);
        // Additive pure tones
        load_all(10'h03f, 10'h000, 3'd0, 1'b1);
        pulse_sync();
        run_cycles(TONE_FRAMES * `FM_SLOTS);
        // Frequency modulation
        load_all(10'h0ff, 10'h000, 3'd0, 1'b0);
        pulse_sync();
        run_cycles(FM_FRAMES * `FM_SLOTS);
        // Every feedback level on both modulators
        for (int f = 1; f < 8; f++) begin
            load_all(10'h0ff, 10'h000, 3'(f), 1'b0);
            pulse_sync();
            run_cycles(FB_FRAMES * `FM_SLOTS);
        end
        // Sync lands at a random point among random writes
        load_all(10'h1ff, 10'h000, 3'($random(seed)), 1'($random(seed)));
        pulse_sync();
        random_activity(MID_FRAMES);
        run_cycles($random(seed) & 3);
        pulse_sync();
        random_activity(MID_FRAMES);
        // Each address in turn gets one random write and a restart
        for (int r = 0; r < RAND_ROUNDS; r++) begin
            write_reg(3'(r), 16'($random(seed)));
            pulse_sync();
            run_cycles(RAND_FRAMES * `FM_SLOTS);
        end
        run_cycles(3 * `FM_SLOTS);
        $display("Checked %0d samples: %0d mismatches, %0d other errors",
                 checked_count, mismatch_count, other_count);
        if (checked_count == 0)
            $display("No sample strobe was seen during the run");
        if (mismatch_count == 0 && other_count == 0 && checked_count > 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

    // Planned run length plus half again
    initial begin
        #(WATCHDOG_TIME);
        $display("Watchdog expired after %0d time units, the run hung", WATCHDOG_TIME);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule
